// ==== logic/spi_flash_cfg.svh ====
`ifndef SPI_FLASH_CFG_SVH
`define SPI_FLASH_CFG_SVH

// Flash opcodes.
`define FLASH_CMD_IDLE	8'h00
`define FLASH_CMD_READ	8'h03
`define FLASH_CMD_PP	8'h02
`define FLASH_CMD_SE	8'hd8
`define FLASH_CMD_BE	8'hc7

// Helpers issued around write-type operations.
`define FLASH_CMD_WREN	8'h06
`define FLASH_CMD_RDSR	8'h05

// Write in progress.
`define FLASH_SR_WIP	0

`endif

// ==== logic/spi_flash_pkg.sv ====
`default_nettype none

package spi_flash_pkg;

	typedef logic [7:0]  flash_op_t;
	typedef logic [23:0] flash_addr_t;
	typedef logic [8:0]  flash_len_t;	// 1 to 256 bytes.
	typedef logic [15:0] clk_div_t;
	typedef logic [7:0]  flash_byte_t;

	////////////////////////////////////////////////////////////////////
	// State machines
	////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_ISSUE,
		SEQ_WAIT
	} seq_state_t;

	typedef enum logic [2:0] {
		FR_IDLE,
		FR_OPCODE,
		FR_ADDR,
		FR_DATA,
		FR_END
	} frame_state_t;

endpackage

`default_nettype wire

// ==== logic/spi_shift_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine import spi_flash_pkg::*; (
	input  wire              clk,
	input  wire              rst_n,

	input  wire clk_div_t    i_clk_div,
	input  wire              i_start,
	input  wire flash_byte_t i_tx,
	output logic             o_done,
	output flash_byte_t      o_rx,

	output logic             o_sclk,
	output logic             o_mosi,
	input  wire              i_miso
);

	logic        busy;
	logic        tick;
	clk_div_t    div_cnt;
	logic [3:0]  edge_cnt;
	flash_byte_t tx_shift;
	flash_byte_t rx_shift;

	// One half-period elapsed.
	assign tick = busy && (div_cnt == i_clk_div);

	// Sixteenth edge ends the byte.
	assign o_done = tick && (edge_cnt == 4'd15);

	assign o_mosi = tx_shift[7];
	assign o_rx   = rx_shift;

	//////////////////////////////////////////////////////////////////////
	// Divider and edge counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			div_cnt  <= '0;
			edge_cnt <= '0;
			o_sclk   <= 1'b0;
		end
		else if (i_start) begin
			busy     <= 1'b1;
			div_cnt  <= '0;
			edge_cnt <= '0;
		end
		else if (busy) begin
			if (tick) begin
				div_cnt  <= '0;
				edge_cnt <= edge_cnt + 4'd1;
				o_sclk   <= ~o_sclk;
				if (edge_cnt == 4'd15)
					busy <= 1'b0;
			end
			else begin
				div_cnt <= div_cnt + 16'd1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Shift registers, MSB first
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (i_start)
			tx_shift <= i_tx;	// First bit out before the first rise.
		else if (tick && o_sclk)
			tx_shift <= {tx_shift[6:0], 1'b0};	// Falling edge.

		if (tick && !o_sclk)
			rx_shift <= {rx_shift[6:0], i_miso};	// Rising edge.
	end

	// A new byte may only start once the previous one has finished.
	assert property (@(posedge clk) disable iff (!rst_n) i_start |-> !busy)
		else $error("byte start while a byte is shifting");

	// SCLK returns low at the end of every byte.
	assert property (@(posedge clk) disable iff (!rst_n) o_done |=> !o_sclk)
		else $error("sclk left high after a byte");

endmodule

`default_nettype wire

// ==== logic/spi_flash_cmd.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_flash_cfg.svh"

module spi_flash_cmd import spi_flash_pkg::*; (
	input  wire              clk,
	input  wire              rst_n,

	input  wire clk_div_t    i_clk_div,
	input  wire flash_op_t   i_cmd,
	input  wire              i_cmd_valid,
	output logic             o_cmd_ack,

	input  wire flash_addr_t i_addr,
	input  wire flash_len_t  i_byte_size,

	output logic             o_data_req,
	input  wire flash_byte_t i_data_in,
	output flash_byte_t      o_data_out,
	output logic             o_data_valid,

	output logic             o_spi_cs,
	output logic             o_spi_dclk,
	output logic             o_spi_mosi,
	input  wire              i_spi_miso
);

	frame_state_t state;
	flash_op_t    cmd_q;
	flash_addr_t  addr_q;
	flash_len_t   len_q;
	flash_len_t   last_idx;
	flash_len_t   byte_cnt;
	logic [1:0]   addr_idx;
	logic         launch;
	logic         has_addr;
	logic         has_data;
	logic         is_write;
	logic         byte_done;
	flash_byte_t  tx_byte;
	flash_byte_t  rx_byte;

	//////////////////////////////////////////////////////////////////////
	// Frame shape from the opcode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		has_addr = (cmd_q == `FLASH_CMD_READ) || (cmd_q == `FLASH_CMD_PP) ||
			(cmd_q == `FLASH_CMD_SE);
		has_data = (cmd_q == `FLASH_CMD_READ) || (cmd_q == `FLASH_CMD_PP) ||
			(cmd_q == `FLASH_CMD_RDSR);
	end

	assign is_write = (cmd_q == `FLASH_CMD_PP);
	assign last_idx = len_q - 9'd1;

	// Byte to send on the next launch.
	always_comb begin
		case (state)
			FR_ADDR: tx_byte = addr_q[23:16];
			FR_DATA: tx_byte = is_write ? i_data_in : 8'h00;
			default: tx_byte = cmd_q;
		endcase
	end

	// Host byte is taken in the same cycle as the request.
	assign o_data_req = launch && (state == FR_DATA) && is_write;

	//////////////////////////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= FR_IDLE;
			cmd_q        <= `FLASH_CMD_IDLE;
			o_spi_cs     <= 1'b1;
			o_cmd_ack    <= 1'b0;
			o_data_valid <= 1'b0;
			launch       <= 1'b0;
			addr_idx     <= '0;
			byte_cnt     <= '0;
		end
		else begin
			launch       <= 1'b0;
			o_cmd_ack    <= 1'b0;
			o_data_valid <= 1'b0;
			case (state)
				FR_IDLE: begin
					if (i_cmd_valid) begin
						cmd_q    <= i_cmd;
						o_spi_cs <= 1'b0;
						launch   <= 1'b1;
						state    <= FR_OPCODE;
					end
				end
				FR_OPCODE: begin
					if (byte_done) begin
						addr_idx <= '0;
						byte_cnt <= '0;
						if (has_addr) begin
							launch <= 1'b1;
							state  <= FR_ADDR;
						end
						else if (has_data) begin
							launch <= 1'b1;
							state  <= FR_DATA;
						end
						else begin
							state <= FR_END;	// WREN and BE.
						end
					end
				end
				FR_ADDR: begin
					if (byte_done) begin
						addr_idx <= addr_idx + 2'd1;
						if (addr_idx != 2'd2) begin
							launch <= 1'b1;
						end
						else if (has_data) begin
							launch <= 1'b1;
							state  <= FR_DATA;
						end
						else begin
							state <= FR_END;
						end
					end
				end
				FR_DATA: begin
					if (byte_done) begin
						o_data_valid <= !is_write;
						byte_cnt     <= byte_cnt + 9'd1;
						if (byte_cnt == last_idx)
							state <= FR_END;
						else
							launch <= 1'b1;
					end
				end
				FR_END: begin
					o_spi_cs  <= 1'b1;
					o_cmd_ack <= 1'b1;
					state     <= FR_IDLE;
				end
				default: state <= FR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FR_IDLE && i_cmd_valid) begin
			addr_q <= i_addr;
			len_q  <= (i_cmd == `FLASH_CMD_RDSR) ? 9'd1 : i_byte_size;
		end
		else if (state == FR_ADDR && byte_done) begin
			addr_q <= {addr_q[15:0], 8'h00};	// Next address byte to the top.
		end

		if (byte_done && state == FR_DATA)
			o_data_out <= rx_byte;
	end

	spi_shift_engine u_shift (
		.clk       ( clk ),
		.rst_n     ( rst_n ),
		.i_clk_div ( i_clk_div ),
		.i_start   ( launch ),
		.i_tx      ( tx_byte ),
		.o_done    ( byte_done ),
		.o_rx      ( rx_byte ),
		.o_sclk    ( o_spi_dclk ),
		.o_mosi    ( o_spi_mosi ),
		.i_miso    ( i_spi_miso )
	);

	// Chip select stays low from the opcode to the end state.
	assert property (@(posedge clk) disable iff (!rst_n)
		(state != FR_IDLE) |-> !o_spi_cs)
		else $error("chip select high inside a frame");

	assert property (@(posedge clk) disable iff (!rst_n) o_data_req |-> !o_spi_cs)
		else $error("data request outside a frame");

endmodule

`default_nettype wire

// ==== logic/spi_flash_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_flash_cfg.svh"

module spi_flash_top import spi_flash_pkg::*; (
	input  wire              clk,
	input  wire              rst_n,

	output logic             o_spi_cs,
	output logic             o_spi_dclk,
	output logic             o_spi_mosi,
	input  wire              i_spi_miso,

	input  wire clk_div_t    i_clk_div,
	input  wire flash_op_t   i_cmd,
	input  wire              i_cmd_valid,
	output logic             o_cmd_ack,

	input  wire flash_addr_t i_addr,
	input  wire flash_len_t  i_byte_size,

	output logic             o_data_req,
	input  wire flash_byte_t i_data_in,
	output flash_byte_t      o_data_out,
	output logic             o_data_valid
);

	seq_state_t state;
	flash_op_t  op_q;
	flash_op_t  cur_cmd;
	logic       supported;
	logic       frame_valid;
	logic       frame_ack;
	logic       wip_q;

	// Host operations that are accepted.
	assign supported = i_cmd inside {`FLASH_CMD_READ, `FLASH_CMD_PP,
		`FLASH_CMD_SE, `FLASH_CMD_BE};

	assign frame_valid = (state == SEQ_ISSUE);

	//////////////////////////////////////////////////////////////////////
	// Operation sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= SEQ_IDLE;
			op_q      <= `FLASH_CMD_IDLE;
			cur_cmd   <= `FLASH_CMD_IDLE;
			o_cmd_ack <= 1'b0;
		end
		else begin
			o_cmd_ack <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					// Host still holds valid in the ack cycle.
					if (i_cmd_valid && supported && !o_cmd_ack) begin
						op_q    <= i_cmd;
						cur_cmd <= (i_cmd == `FLASH_CMD_READ) ?
							`FLASH_CMD_READ : `FLASH_CMD_WREN;
						state   <= SEQ_ISSUE;
					end
				end
				SEQ_ISSUE: state <= SEQ_WAIT;	// One-cycle frame request.
				SEQ_WAIT: begin
					if (frame_ack) begin
						case (cur_cmd)
							`FLASH_CMD_READ: begin
								o_cmd_ack <= 1'b1;
								cur_cmd   <= `FLASH_CMD_IDLE;
								state     <= SEQ_IDLE;
							end
							`FLASH_CMD_WREN: begin
								cur_cmd <= op_q;
								state   <= SEQ_ISSUE;
							end
							`FLASH_CMD_RDSR: begin
								if (!wip_q) begin
									o_cmd_ack <= 1'b1;
									cur_cmd   <= `FLASH_CMD_IDLE;
									state     <= SEQ_IDLE;
								end
								else begin
									state <= SEQ_ISSUE;	// Poll again.
								end
							end
							default: begin
								cur_cmd <= `FLASH_CMD_RDSR;	// After PP, SE or BE.
								state   <= SEQ_ISSUE;
							end
						endcase
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// Status byte arrives before the frame ack.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wip_q <= 1'b1;
		else if (o_data_valid && cur_cmd == `FLASH_CMD_RDSR)
			wip_q <= o_data_out[`FLASH_SR_WIP];
	end

	spi_flash_cmd u_spi_cmd (
		.clk          ( clk ),
		.rst_n        ( rst_n ),
		.i_clk_div    ( i_clk_div ),
		.i_cmd        ( cur_cmd ),
		.i_cmd_valid  ( frame_valid ),
		.o_cmd_ack    ( frame_ack ),
		.i_addr       ( i_addr ),
		.i_byte_size  ( i_byte_size ),
		.o_data_req   ( o_data_req ),
		.i_data_in    ( i_data_in ),
		.o_data_out   ( o_data_out ),
		.o_data_valid ( o_data_valid ),
		.o_spi_cs     ( o_spi_cs ),
		.o_spi_dclk   ( o_spi_dclk ),
		.o_spi_mosi   ( o_spi_mosi ),
		.i_spi_miso   ( i_spi_miso )
	);

	assert property (@(posedge clk) disable iff (!rst_n) o_cmd_ack |=> !o_cmd_ack)
		else $error("host ack longer than one cycle");

endmodule

`default_nettype wire

// ==== dv/spi_flash_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_flash_cfg.svh"

module spi_flash_model (
	input  wire  i_cs,
	input  wire  i_sclk,
	input  wire  i_mosi,
	output logic o_miso
);

	localparam int SECTOR_BITS = 12;	// 4 KiB sectors.

	logic [7:0]  mem [0:65535];
	logic [7:0]  in_shift;
	logic [7:0]  out_byte;
	logic [7:0]  opcode;
	logic [23:0] addr;
	logic [7:0]  page_off;
	logic        wel;
	int          busy_cnt;
	int          bit_cnt;
	int          byte_idx;

	initial begin
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'hff;
		wel      = 1'b0;
		busy_cnt = 0;
		o_miso   = 1'b0;
		out_byte = 8'h00;
	end

	task automatic take_byte(input logic [7:0] b);
		if (byte_idx == 0) begin
			opcode = b;
			if (b == `FLASH_CMD_RDSR)
				out_byte = {6'd0, wel, busy_cnt != 0};
		end
		else if (byte_idx <= 3) begin
			addr = {addr[15:0], b};
			page_off = addr[7:0];
			if (byte_idx == 3 && opcode == `FLASH_CMD_READ) begin
				out_byte = mem[addr[15:0]];
				addr = addr + 24'd1;
			end
		end
		else if (opcode == `FLASH_CMD_READ) begin
			out_byte = mem[addr[15:0]];
			addr = addr + 24'd1;
		end
		else if (opcode == `FLASH_CMD_PP && wel) begin
			mem[{addr[15:8], page_off}] = mem[{addr[15:8], page_off}] & b;	// Page wrap.
			page_off = page_off + 8'd1;
		end
	endtask

	always @(negedge i_cs) begin
		bit_cnt  = 0;
		byte_idx = 0;
		out_byte = 8'h00;
		o_miso   = 1'b0;
	end

	// Mode 0: sample on the rising edge.
	always @(posedge i_sclk) begin
		if (!i_cs) begin
			in_shift = {in_shift[6:0], i_mosi};
			bit_cnt  = bit_cnt + 1;
			if (bit_cnt == 8) begin
				bit_cnt = 0;
				take_byte(in_shift);
				byte_idx = byte_idx + 1;
			end
		end
	end

	always @(negedge i_sclk) begin
		if (!i_cs)
			o_miso = out_byte[7 - bit_cnt];
	end

	// Commands take effect when chip select rises.
	always @(posedge i_cs) begin
		case (opcode)
			`FLASH_CMD_WREN: wel = 1'b1;
			`FLASH_CMD_RDSR: if (busy_cnt != 0) busy_cnt = busy_cnt - 1;
			`FLASH_CMD_PP: if (wel) begin
				wel      = 1'b0;
				busy_cnt = 3;
			end
			`FLASH_CMD_SE: if (wel) begin
				for (int i = 0; i < (1 << SECTOR_BITS); i++)
					mem[{addr[15:SECTOR_BITS], 12'd0} + i[15:0]] = 8'hff;
				wel      = 1'b0;
				busy_cnt = 3;
			end
			`FLASH_CMD_BE: if (wel) begin
				for (int i = 0; i < 65536; i++)
					mem[i] = 8'hff;
				wel      = 1'b0;
				busy_cnt = 3;
			end
			default: ;
		endcase
		opcode = `FLASH_CMD_IDLE;
	end

endmodule

`default_nettype wire

// ==== dv/spi_flash_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_flash_cfg.svh"

module spi_flash_tb import spi_flash_pkg::*; ();

	logic        clk;
	logic        rst_n;
	wire         spi_cs;
	wire         spi_dclk;
	wire         spi_mosi;
	wire         spi_miso;
	clk_div_t    i_clk_div;
	flash_op_t   i_cmd;
	logic        i_cmd_valid;
	wire         o_cmd_ack;
	flash_addr_t i_addr;
	flash_len_t  i_byte_size;
	wire         o_data_req;
	flash_byte_t i_data_in;
	flash_byte_t o_data_out;
	wire         o_data_valid;

	logic [7:0]  ref_mem [0:65535];
	flash_byte_t wr_buf [0:255];
	logic [31:0] lfsr = 32'h5d5239c0;
	logic [15:0] rd_addr;
	logic        reading;
	logic [7:0]  last_sr;
	int          rd_idx;
	int          wr_idx;
	int          rdsr_cnt;
	int          hi_cnt;

	initial clk = 1'b0;
	always #4 clk = ~clk;

	spi_flash_top UUT (
		.clk(clk), .rst_n(rst_n),
		.o_spi_cs(spi_cs), .o_spi_dclk(spi_dclk), .o_spi_mosi(spi_mosi), .i_spi_miso(spi_miso),
		.i_clk_div(i_clk_div), .i_cmd(i_cmd), .i_cmd_valid(i_cmd_valid), .o_cmd_ack(o_cmd_ack),
		.i_addr(i_addr), .i_byte_size(i_byte_size),
		.o_data_req(o_data_req), .i_data_in(i_data_in),
		.o_data_out(o_data_out), .o_data_valid(o_data_valid)
	);

	spi_flash_model u_flash (.i_cs(spi_cs), .i_sclk(spi_dclk), .i_mosi(spi_mosi), .o_miso(spi_miso));

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	// Galois LFSR, one step per bit.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Response checkers
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (o_data_valid) begin
			if (reading) begin
				assert (o_data_out == ref_mem[rd_addr + rd_idx[15:0]])
				else stop_on_error($sformatf("error: o_data_out got %h expected %h",
					o_data_out, ref_mem[rd_addr + rd_idx[15:0]]));
				rd_idx = rd_idx + 1;
			end
			else begin
				rdsr_cnt = rdsr_cnt + 1;
				last_sr  = o_data_out;
			end
		end
	end

	// Host advances its write byte on each request.
	always @(posedge clk) begin
		if (o_data_req) begin
			wr_idx = wr_idx + 1;
			i_data_in <= wr_buf[wr_idx[7:0]];
		end
	end

	// SCLK high phase is one half-period.
	always @(posedge clk) begin
		if (spi_dclk)
			hi_cnt = hi_cnt + 1;
		else if (hi_cnt != 0) begin
			assert (hi_cnt == int'(i_clk_div) + 1)
			else stop_on_error($sformatf("error: sclk half-period got %h expected %h",
				hi_cnt, int'(i_clk_div) + 1));
			hi_cnt = 0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Host operations
	//////////////////////////////////////////////////////////////////////

	task automatic run_op(input flash_op_t op, input logic [15:0] a, input flash_len_t len);
		logic [7:0] off;
		if (op == `FLASH_CMD_PP) begin
			off = a[7:0];
			for (int k = 0; k < int'(len); k++) begin
				ref_mem[{a[15:8], off}] = ref_mem[{a[15:8], off}] & wr_buf[k];
				off = off + 8'd1;
			end
		end
		else if (op == `FLASH_CMD_SE) begin
			for (int i = 0; i < 4096; i++)
				ref_mem[{a[15:12], 12'd0} + i[15:0]] = 8'hff;
		end
		else if (op == `FLASH_CMD_BE) begin
			for (int i = 0; i < 65536; i++)
				ref_mem[i] = 8'hff;
		end
		@(posedge clk);
		reading  = (op == `FLASH_CMD_READ);
		rd_addr  = a;
		rd_idx   = 0;
		wr_idx   = 0;
		rdsr_cnt = 0;
		last_sr  = 8'hff;
		i_data_in   <= wr_buf[0];
		i_cmd       <= op;
		i_addr      <= {8'h00, a};
		i_byte_size <= len;
		i_cmd_valid <= 1'b1;
		do @(posedge clk); while (!o_cmd_ack);
		i_cmd_valid <= 1'b0;
		if (op == `FLASH_CMD_READ) begin
			assert (rd_idx == int'(len))
			else stop_on_error($sformatf("error: read bytes got %h expected %h", rd_idx, len));
		end
		else begin
			assert (rdsr_cnt >= 4 && !last_sr[`FLASH_SR_WIP])
			else stop_on_error("ack came before the status poll showed the write finished");
		end
		reading = 1'b0;
	endtask

	task automatic fill_random(input flash_len_t len);
		for (int k = 0; k < int'(len); k++)
			wr_buf[k] = 8'(rand_bits(8));
	endtask

	task automatic check_unsupported(input flash_op_t op);
		@(posedge clk);
		i_cmd       <= op;
		i_cmd_valid <= 1'b1;
		repeat (2000) begin
			@(posedge clk);
			assert (spi_cs && !o_cmd_ack)
			else stop_on_error("unsupported opcode caused bus activity or an ack");
		end
		i_cmd_valid <= 1'b0;
	endtask

	task automatic program_and_read();
		logic [15:0] a;
		flash_len_t  len;
		a   = {8'(rand_bits(8)), 1'b1, 7'(rand_bits(7))};	// Upper half of a page.
		len = flash_len_t'(rand_bits(7)) + 9'd129;	// Runs past the page end.
		fill_random(len);
		run_op(`FLASH_CMD_PP, a, len);
		run_op(`FLASH_CMD_READ, {a[15:8], 8'h00}, 9'd256);	// Whole page.
	endtask

	initial begin
		logic [15:0] a;
		for (int i = 0; i < 65536; i++)
			ref_mem[i] = 8'hff;
		hi_cnt  = 0;
		reading = 1'b0;
		rst_n       = 1'b0;
		i_clk_div   = 16'd3;
		i_cmd       = `FLASH_CMD_IDLE;
		i_cmd_valid = 1'b0;
		i_addr      = '0;
		i_byte_size = 9'd1;
		i_data_in   = 8'h00;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		run_op(`FLASH_CMD_BE, 16'h0000, 9'd1);
		run_op(`FLASH_CMD_READ, 16'(rand_bits(16)), flash_len_t'(rand_bits(8)) + 9'd1);
		program_and_read();

		// Erase one sector, the other keeps its byte.
		a = {4'h3, 12'(rand_bits(12))};
		wr_buf[0] = 8'h5a;
		run_op(`FLASH_CMD_PP, a, 9'd1);
		run_op(`FLASH_CMD_PP, {4'h9, a[11:0]}, 9'd1);
		run_op(`FLASH_CMD_SE, a, 9'd1);
		run_op(`FLASH_CMD_READ, a, 9'd1);
		run_op(`FLASH_CMD_READ, {4'h9, a[11:0]}, 9'd1);

		check_unsupported(8'h9f);

		@(posedge clk);
		i_clk_div <= 16'd1;
		program_and_read();

		$display("Regression passed");
		$finish;
	end

	// Longest case is a few 256 byte frames at the slow divider.
	initial begin
		#4_000_000;
		$display("watchdog expired before the tests finished");
		$display("Regression failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+logic
logic/spi_flash_pkg.sv
logic/spi_shift_engine.sv
logic/spi_flash_cmd.sv
logic/spi_flash_top.sv
dv/spi_flash_model.sv
dv/spi_flash_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SPI flash regression with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
	-f all.f \
	--top-module spi_flash_tb \
	-Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vspi_flash_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
